//--- verilog/cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache_pkg
// Shared types and line geometry for the
// two-way pipelined data cache: CPU word,
// cacheline sizes and controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cache_pkg;

    // CPU address or data word
    typedef logic [31:0] rv32i_word;

    // 32-byte line, also the memory bus width
    localparam int unsigned line_bits  = 256;
    localparam int unsigned line_bytes = 32;

    // byte offset bits inside a line
    localparam int unsigned s_offset = 5;

    // controller states
    typedef enum logic [1:0] {
        st_lookup,      // compare and serve hits
        st_writeback,   // dirty victim goes to memory
        st_fill,        // missing line comes from memory
        st_refill_done  // re-read arrays, then retry lookup
    } cache_state_t;

endpackage : cache_pkg

//--- verilog/bus_adapter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus_adapter
// Steers 32-bit CPU words and byte enables
// into 256-bit line lanes, and picks the
// addressed word out of a cacheline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_adapter (
    input  cache_pkg::rv32i_word                mem_wdata,
    input  logic [3:0]                          mem_byte_enable,
    input  cache_pkg::rv32i_word                address,
    input  cache_pkg::rv32i_word                prev_address,
    input  logic [cache_pkg::line_bits-1:0]     mem_rdata256,
    output logic [cache_pkg::line_bits-1:0]     mem_wdata256,
    output logic [cache_pkg::line_bytes-1:0]    mem_byte_enable256,
    output cache_pkg::rv32i_word                mem_rdata
);
    import cache_pkg::*;

    logic [s_offset-3:0] wr_word;
    logic [s_offset-3:0] rd_word;

    // write side follows the live request
    assign wr_word = address[s_offset-1:2];
    // read side follows the registered lookup
    assign rd_word = prev_address[s_offset-1:2];

    // word copied into every lane, enables pick the lane
    assign mem_wdata256 = {(line_bits / 32){mem_wdata}};
    assign mem_byte_enable256 = {{(line_bytes - 4){1'b0}}, mem_byte_enable}
                                << {wr_word, 2'b00};

    assign mem_rdata = mem_rdata256[{rd_word, 5'b00000} +: 32];

endmodule : bus_adapter

//--- verilog/cache_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache_control
// FSM for the pipelined data cache that
// serves hits from the lookup stage,
// sequences writeback and fill on a miss
// and holds the lookup stage on a stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_control (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic mem_read,
    input  logic mem_write,
    input  logic pmem_resp,
    input  logic cache_hit,
    input  logic hit1,
    input  logic dirty_o,
    input  logic lru_out,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic load_cache,
    output logic source_sel,
    output logic way_sel,
    output logic load_dirty,
    output logic dirty_sel,
    output logic load_lru,
    output logic addrmux_sel,
    output logic advance
);
    import cache_pkg::*;

    cache_state_t state;
    cache_state_t state_next;

    // a request sits in the lookup register
    logic req_valid;
    logic served;

    assign served = req_valid && cache_hit && !stall;

    always_comb begin
        state_next  = state;
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        load_cache  = 1'b0;
        source_sel  = 1'b0;
        way_sel     = lru_out;
        load_dirty  = 1'b0;
        dirty_sel   = 1'b0;
        load_lru    = 1'b0;
        addrmux_sel = 1'b0;
        advance     = 1'b0;
        case (state)
            st_lookup: begin
                way_sel = hit1;
                advance = !stall && (!req_valid || cache_hit);
                if (served) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    // write hit merges bytes and marks the line dirty
                    load_cache = mem_write;
                    load_dirty = mem_write;
                    dirty_sel  = 1'b1;
                end else if (req_valid && !stall) begin
                    state_next = dirty_o ? st_writeback : st_fill;
                end
            end
            st_writeback: begin
                pmem_write  = 1'b1;
                addrmux_sel = 1'b1;
                if (pmem_resp) begin
                    state_next = st_fill;
                end
            end
            st_fill: begin
                pmem_read  = 1'b1;
                source_sel = 1'b1;
                // line is taken only once the core lets go of stall
                if (pmem_resp && !stall) begin
                    load_cache = 1'b1;
                    load_dirty = 1'b1;
                    state_next = st_refill_done;
                end
            end
            st_refill_done: begin
                state_next = st_lookup;
            end
            default: begin
                state_next = st_lookup;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_lookup;
            req_valid <= 1'b0;
        end else begin
            state <= state_next;
            // a served request frees the stage for the next one
            if (advance) begin
                req_valid <= !req_valid && (mem_read || mem_write);
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    assert property (@(posedge clk) disable iff (reset) stall |-> !mem_resp)
        else $error("mem_resp high during stall");

endmodule : cache_control

//--- verilog/cache_datapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cache_datapath
// Two-way tag, valid, dirty and data arrays
// with per-set LRU, read synchronously; the
// lookup register, hit compare, line merge
// and memory address select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cache_datapath #(
    parameter int s_index = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  cache_pkg::rv32i_word                mem_address,
    input  logic [cache_pkg::line_bits-1:0]     mem_wdata256,
    input  logic [cache_pkg::line_bytes-1:0]    mem_byte_enable256,
    input  logic [cache_pkg::line_bits-1:0]     pmem_rdata,
    input  logic                                load_cache,
    input  logic                                source_sel,
    input  logic                                way_sel,
    input  logic                                load_dirty,
    input  logic                                dirty_sel,
    input  logic                                load_lru,
    input  logic                                addrmux_sel,
    input  logic                                advance,
    output logic                                cache_hit,
    output logic                                hit1,
    output logic                                dirty_o,
    output logic                                lru_out,
    output logic [cache_pkg::line_bits-1:0]     cacheline_data_out,
    output cache_pkg::rv32i_word                pmem_address,
    output cache_pkg::rv32i_word                prev_address
);
    import cache_pkg::*;

    localparam int s_tag    = 32 - s_offset - s_index;
    localparam int num_sets = 2**s_index;

    // arrays indexed [way][set]
    logic [s_tag-1:0]     tag_mem   [2][num_sets];
    logic [line_bits-1:0] data_mem  [2][num_sets];
    logic                 valid_mem [2][num_sets];
    logic                 dirty_mem [2][num_sets];
    logic                 lru_mem   [num_sets];

    // synchronous read outputs
    logic [s_tag-1:0]     tag_rd  [2];
    logic [line_bits-1:0] data_rd [2];
    logic [1:0]           valid_rd;
    logic [1:0]           dirty_rd;
    logic                 lru_rd;

    logic [s_index-1:0]   rd_index;
    logic [s_index-1:0]   wr_index;
    logic [s_tag-1:0]     prev_tag;
    logic                 hit0;
    logic [line_bits-1:0] merged_line;
    logic [line_bits-1:0] line_in;

    // arrays look ahead to the incoming address while the stage moves
    assign rd_index = advance ? mem_address[s_offset +: s_index]
                              : prev_address[s_offset +: s_index];
    assign wr_index = prev_address[s_offset +: s_index];
    assign prev_tag = prev_address[31 -: s_tag];

    always_ff @(posedge clk) begin
        if (advance) begin
            prev_address <= mem_address;
        end
    end

    always_ff @(posedge clk) begin
        if (load_cache) begin
            tag_mem[way_sel][wr_index]  <= prev_tag;
            data_mem[way_sel][wr_index] <= line_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_mem[0][s] <= 1'b0;
                valid_mem[1][s] <= 1'b0;
                dirty_mem[0][s] <= 1'b0;
                dirty_mem[1][s] <= 1'b0;
                lru_mem[s]      <= 1'b0;
            end
        end else begin
            if (load_cache) begin
                valid_mem[way_sel][wr_index] <= 1'b1;
            end
            if (load_dirty) begin
                dirty_mem[way_sel][wr_index] <= dirty_sel;
            end
            // the way just used is now the most recent
            if (load_lru) begin
                lru_mem[wr_index] <= ~way_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            tag_rd[w]   <= tag_mem[w][rd_index];
            data_rd[w]  <= data_mem[w][rd_index];
            valid_rd[w] <= valid_mem[w][rd_index];
            dirty_rd[w] <= dirty_mem[w][rd_index];
        end
        lru_rd <= lru_mem[rd_index];
    end

    // byte merge of CPU data over the hit line
    always_comb begin
        for (int b = 0; b < line_bytes; b++) begin
            merged_line[8*b +: 8] = mem_byte_enable256[b] ? mem_wdata256[8*b +: 8]
                                                          : data_rd[way_sel][8*b +: 8];
        end
    end

    assign line_in = source_sel ? pmem_rdata : merged_line;

    assign hit0      = valid_rd[0] && (tag_rd[0] == prev_tag);
    assign hit1      = valid_rd[1] && (tag_rd[1] == prev_tag);
    assign cache_hit = hit0 || hit1;
    assign lru_out   = lru_rd;
    assign dirty_o   = dirty_rd[lru_rd];

    // victim line during writeback, hit line otherwise
    assign cacheline_data_out = addrmux_sel ? data_rd[lru_rd] : data_rd[hit1];
    assign pmem_address = addrmux_sel ? {tag_rd[lru_rd], wr_index, {s_offset{1'b0}}}
                                      : {prev_address[31:s_offset], {s_offset{1'b0}}};

    // a fill never installs a tag that already hits in the other way
    assert property (@(posedge clk) disable iff (reset) !(hit0 && hit1))
        else $error("both ways hit for address %h", prev_address);

endmodule : cache_datapath

//--- verilog/pipelined_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipelined_cache
// Two-way write-back data cache between the
// core's word port and a 256-bit memory
// port, with a two-stage lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pipelined_cache #(
    parameter int s_index = 3
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stall,
    // core port
    input  logic                                mem_read,
    input  logic                                mem_write,
    input  logic [3:0]                          mem_byte_enable,
    input  cache_pkg::rv32i_word                mem_address,
    input  cache_pkg::rv32i_word                mem_wdata,
    output logic                                mem_resp,
    output cache_pkg::rv32i_word                mem_rdata,
    // memory port
    input  logic [cache_pkg::line_bits-1:0]     pmem_rdata,
    input  logic                                pmem_resp,
    output logic [cache_pkg::line_bits-1:0]     pmem_wdata,
    output logic [31:0]                         pmem_address,
    output logic                                pmem_read,
    output logic                                pmem_write
);
    import cache_pkg::*;

    // control to datapath
    logic load_cache;
    logic source_sel;
    logic way_sel;
    logic load_dirty;
    logic dirty_sel;
    logic load_lru;
    logic addrmux_sel;
    logic advance;

    // datapath to control
    logic cache_hit;
    logic hit1;
    logic dirty_o;
    logic lru_out;

    // lane steering
    logic [line_bits-1:0]  cacheline_data_out;
    logic [line_bits-1:0]  mem_wdata256;
    logic [line_bytes-1:0] mem_byte_enable256;
    rv32i_word             prev_address;

    assign pmem_wdata = cacheline_data_out;

    cache_control control (.*);

    cache_datapath #(.s_index(s_index)) datapath (.*);

    bus_adapter adapter (
        .mem_wdata          (mem_wdata),
        .mem_byte_enable    (mem_byte_enable),
        .address            (mem_address),
        .prev_address       (prev_address),
        .mem_rdata256       (cacheline_data_out),
        .mem_wdata256       (mem_wdata256),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_rdata          (mem_rdata)
    );

endmodule : pipelined_cache

//--- tb/pmem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pmem_model
// Behavioral 256-bit line memory with a
// fixed response latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pmem_model #(
    parameter int latency   = 4,
    parameter int num_lines = 256
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         pmem_read,
    input  logic         pmem_write,
    input  logic [31:0]  pmem_address,
    input  logic [255:0] pmem_wdata,
    output logic [255:0] pmem_rdata,
    output logic         pmem_resp
);
    localparam int idx_bits = $clog2(num_lines);

    logic [255:0]        lines [num_lines];
    logic [idx_bits-1:0] idx;
    logic                busy;
    logic                is_read;
    int                  count;

    assign idx = pmem_address[5 +: idx_bits];

    always @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            count     <= 0;
            pmem_resp <= 1'b0;
            // word at byte address A holds A xor 5a5a0000
            for (int l = 0; l < num_lines; l++) begin
                for (int w = 0; w < 8; w++) begin
                    lines[l][32*w +: 32] <= (l * 32 + w * 4) ^ 32'h5a5a0000;
                end
            end
        end else if (pmem_resp) begin
            // a read answer stays up until pmem_read falls, a write answer lasts one cycle
            if (!is_read || !pmem_read) begin
                pmem_resp <= 1'b0;
                busy      <= 1'b0;
            end
        end else if (busy) begin
            if (count == latency - 1) begin
                pmem_resp <= 1'b1;
                if (is_read) begin
                    pmem_rdata <= lines[idx];
                end else begin
                    lines[idx] <= pmem_wdata;
                end
            end
            count <= count + 1;
        end else if (pmem_read || pmem_write) begin
            busy    <= 1'b1;
            is_read <= pmem_read;
            count   <= 1;
        end
    end

endmodule : pmem_model

//--- tb/tb_pipelined_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_pipelined_cache
// Testbench for the pipelined data cache
// that runs a stimulus table against a
// shadow memory and checks data, fills
// and evictions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_pipelined_cache;
    import cache_pkg::*;

    localparam int   timeout_cycles = 200;
    localparam logic rd = 1'b0;
    localparam logic wr = 1'b1;

    // victim holds the expected writeback line address or zero
    typedef struct packed {
        logic       write;
        rv32i_word  address;
        logic [3:0] byte_enable;
        rv32i_word  data;
        int         stall_cycles;
        logic       fill;
        rv32i_word  victim;
    } entry_t;

    logic         clk;
    logic         reset;
    logic         stall;
    logic         mem_read;
    logic         mem_write;
    logic [3:0]   mem_byte_enable;
    rv32i_word    mem_address;
    rv32i_word    mem_wdata;
    rv32i_word    mem_rdata;
    logic         mem_resp;
    logic [255:0] pmem_rdata;
    logic [255:0] pmem_wdata;
    logic [31:0]  pmem_address;
    logic         pmem_read;
    logic         pmem_write;
    logic         pmem_resp;

    entry_t       stim_q[$];
    rv32i_word    shadow [2048];
    integer       seed;
    int           fill_count;
    int           wb_count;
    logic         read_seen;
    rv32i_word    wb_address;
    logic [255:0] wb_line;

    pipelined_cache #(.s_index(3)) dut (.*);

    pmem_model #(.latency(4)) memory (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // count fill requests and capture accepted writebacks
    always @(negedge clk) begin
        read_seen <= pmem_read;
        if (reset) begin
            fill_count <= 0;
            wb_count   <= 0;
        end else begin
            if (pmem_read && !read_seen) begin
                fill_count <= fill_count + 1;
            end
            if (pmem_write && pmem_resp) begin
                wb_count   <= wb_count + 1;
                wb_address <= pmem_address;
                wb_line    <= pmem_wdata;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Error: %s is %h, expected %h", name, got, expected));
        end
    endtask

    task automatic add_entry(input logic write, input rv32i_word address,
                             input logic [3:0] be, input rv32i_word data,
                             input int stall_cycles, input logic fill,
                             input rv32i_word victim);
        entry_t e;
        e.write        = write;
        e.address      = address;
        e.byte_enable  = be;
        e.data         = data;
        e.stall_cycles = stall_cycles;
        e.fill         = fill;
        e.victim       = victim;
        stim_q.push_back(e);
    endtask

    task automatic load_stimulus();
        // cold miss in set 2 then hits
        add_entry(rd, 32'h040, 4'hf, 32'h0, 0, 1'b1, 32'h0);
        add_entry(rd, 32'h044, 4'hf, 32'h0, 0, 1'b0, 32'h0);
        // partial writes into line A of set 3
        add_entry(wr, 32'h064, 4'b0001, $random(seed), 0, 1'b1, 32'h0);
        add_entry(rd, 32'h064, 4'hf, 32'h0, 0, 1'b0, 32'h0);
        add_entry(wr, 32'h068, 4'b1100, $random(seed), 0, 1'b0, 32'h0);
        add_entry(rd, 32'h068, 4'hf, 32'h0, 0, 1'b0, 32'h0);
        add_entry(wr, 32'h07c, 4'b1111, $random(seed), 0, 1'b0, 32'h0);
        add_entry(rd, 32'h07c, 4'hf, 32'h0, 0, 1'b0, 32'h0);
        // B fills the other way and C evicts dirty A before A returns
        add_entry(rd, 32'h160, 4'hf, 32'h0, 0, 1'b1, 32'h0);
        add_entry(rd, 32'h260, 4'hf, 32'h0, 0, 1'b1, 32'h060);
        add_entry(rd, 32'h064, 4'hf, 32'h0, 0, 1'b1, 32'h0);
        add_entry(rd, 32'h07c, 4'hf, 32'h0, 0, 1'b0, 32'h0);
        // in set 5 the touched A survives C while B does not
        add_entry(rd, 32'h0a0, 4'hf, 32'h0, 0, 1'b1, 32'h0);
        add_entry(rd, 32'h1a0, 4'hf, 32'h0, 0, 1'b1, 32'h0);
        add_entry(rd, 32'h0a4, 4'hf, 32'h0, 0, 1'b0, 32'h0);
        add_entry(rd, 32'h2a0, 4'hf, 32'h0, 0, 1'b1, 32'h0);
        add_entry(rd, 32'h0a8, 4'hf, 32'h0, 0, 1'b0, 32'h0);
        add_entry(rd, 32'h1ac, 4'hf, 32'h0, 0, 1'b1, 32'h0);
        // requests held under stall
        add_entry(rd, 32'h1a4, 4'hf, 32'h0, 5, 1'b0, 32'h0);
        add_entry(rd, 32'h300, 4'hf, 32'h0, 5, 1'b1, 32'h0);
        add_entry(wr, 32'h304, 4'b1111, $random(seed), 3, 1'b0, 32'h0);
        add_entry(rd, 32'h304, 4'hf, 32'h0, 0, 1'b0, 32'h0);
    endtask

    task automatic apply_entry(input entry_t e, input int n);
        int fills_before;
        int wbs_before;
        int cycles;
        logic got;
        @(posedge clk);
        #1;
        fills_before    = fill_count;
        wbs_before      = wb_count;
        mem_read        = !e.write;
        mem_write       = e.write;
        mem_address     = e.address;
        mem_byte_enable = e.byte_enable;
        mem_wdata       = e.data;
        stall           = (e.stall_cycles != 0);
        for (int c = 0; c < e.stall_cycles; c++) begin
            @(negedge clk);
            check_value("mem_resp", 32'(mem_resp), 32'h0);
        end
        if (e.stall_cycles != 0) begin
            @(posedge clk);
            #1 stall = 1'b0;
        end
        cycles = 0;
        got    = 1'b0;
        while (!got) begin
            @(negedge clk);
            cycles++;
            if (mem_resp) begin
                got = 1'b1;
            end else if (cycles >= timeout_cycles) begin
                abort_run($sformatf("no mem_resp within %0d cycles for entry %0d",
                                    timeout_cycles, n));
            end
        end
        if (e.write) begin
            for (int b = 0; b < 4; b++) begin
                if (e.byte_enable[b]) begin
                    shadow[e.address[12:2]][8*b +: 8] = e.data[8*b +: 8];
                end
            end
        end else begin
            check_value("mem_rdata", mem_rdata, shadow[e.address[12:2]]);
        end
        check_value("fill count", fill_count - fills_before, 32'(e.fill));
        check_value("writeback count", wb_count - wbs_before, 32'(e.victim != 0));
        if (!e.fill && e.victim == 0) begin
            check_value("hit latency", cycles, 2);
        end
        if (e.victim != 0) begin
            check_value("pmem_address", wb_address, e.victim);
            for (int w = 0; w < 8; w++) begin
                check_value("pmem_wdata", wb_line[32*w +: 32],
                            shadow[e.victim[12:2] + 11'(w)]);
            end
        end
    endtask

    initial begin
        seed            = 32'he9a45e37;
        reset           = 1'b1;
        stall           = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = 4'h0;
        mem_address     = 32'h0;
        mem_wdata       = 32'h0;
        for (int i = 0; i < 2048; i++) begin
            shadow[i] = (i * 4) ^ 32'h5a5a0000;
        end
        load_stimulus();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        for (int n = 0; n < stim_q.size(); n++) begin
            apply_entry(stim_q[n], n);
        end
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        $display("Result: PASSED");
        $finish;
    end

endmodule : tb_pipelined_cache

//--- verilog.f
verilog/cache_pkg.sv
verilog/bus_adapter.sv
verilog/cache_control.sv
verilog/cache_datapath.sv
verilog/pipelined_cache.sv
tb/pmem_model.sv
tb/tb_pipelined_cache.sv

//--- Makefile
# Verilator build and run for the pipelined cache testbench

VERILATOR ?= verilator
TOP       ?= tb_pipelined_cache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the run passes only when the pass message shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
